// File: verilog/noc_router_params.svh
/* Sizing macros for the east-edge mesh router */

`ifndef NOC_ROUTER_PARAMS_SVH
`define NOC_ROUTER_PARAMS_SVH

// Flit is destination address plus payload
`define ROUTER_FLIT_W    16
`define ROUTER_COORD_W   4

// Input FIFO depth, also the starting credit count
`define ROUTER_BUF_DEPTH 4

// Port order N=0 S=1 W=2 L=3
`define ROUTER_PORTS     4

`endif

// File: verilog/noc_router_pkg.sv
/* Shared router types: mesh coordinates, flits, links and counters */

`include "noc_router_params.svh"

package noc_router_pkg;

  typedef logic [`ROUTER_COORD_W-1:0] coord_t;

  // y sits above x, matching the YX routing order
  typedef struct packed {
    coord_t y;
    coord_t x;
  } router_addr_t;

  typedef logic [`ROUTER_FLIT_W-2*`ROUTER_COORD_W-1:0] payload_t;

  typedef struct packed {
    router_addr_t dest;
    payload_t     payload;
  } flit_t;

  // One direction of a port
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  typedef logic [$clog2(`ROUTER_PORTS)-1:0] port_idx_t;

  // Needs to hold 0 up to the full depth
  typedef logic [$clog2(`ROUTER_BUF_DEPTH+1)-1:0] credit_cnt_t;

endpackage

// File: verilog/input_buffer.sv
/* Input port FIFO: stores arriving flits, exposes the head flit and
   returns one credit upstream per pop */

`timescale 1ns/1ns
`include "noc_router_params.svh"

module input_buffer (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  noc_router_pkg::link_t link_i,
  input  logic                  pop_i,
  output noc_router_pkg::flit_t head_o,
  output logic                  empty_o,
  output logic                  credit_o
);

  localparam int PTR_W = $clog2(`ROUTER_BUF_DEPTH);

  noc_router_pkg::flit_t       mem [`ROUTER_BUF_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  noc_router_pkg::credit_cnt_t count;
  logic                        full;

  assign full    = (count == noc_router_pkg::credit_cnt_t'(`ROUTER_BUF_DEPTH));
  assign empty_o = (count == '0);
  assign head_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (link_i.valid) begin
      mem[wr_ptr] <= link_i.flit;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      if (link_i.valid) begin
        if (wr_ptr == PTR_W'(`ROUTER_BUF_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop_i) begin
        if (rd_ptr == PTR_W'(`ROUTER_BUF_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Simultaneous write and pop leave occupancy as is
      if (link_i.valid && !pop_i) begin
        count <= count + 1'b1;
      end else if (pop_i && !link_i.valid) begin
        count <= count - 1'b1;
      end
      credit_o <= pop_i;
    end
  end

  // Upstream honours credits, so a full FIFO never sees a write
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n_i)
    link_i.valid |-> !full);

  // The arbiter only grants inputs with a head flit
  a_no_underrun: assert property (@(posedge clk) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

// File: verilog/credit_counter.sv
/* Output credit counter: tracks free slots in the downstream buffer */

`timescale 1ns/1ns
`include "noc_router_params.svh"

module credit_counter (
  input  logic clk,
  input  logic rst_n_i,
  input  logic send_i,
  input  logic credit_i,
  output logic avail_o
);

  noc_router_pkg::credit_cnt_t cnt;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt <= noc_router_pkg::credit_cnt_t'(`ROUTER_BUF_DEPTH);
    end else begin
      case ({send_i, credit_i})
        2'b10:   cnt <= cnt - 1'b1;
        2'b01:   cnt <= cnt + 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  assign avail_o = (cnt != '0);

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
    send_i |-> cnt != '0);

  // Downstream cannot return more slots than it has
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
    (credit_i && !send_i) |-> cnt < noc_router_pkg::credit_cnt_t'(`ROUTER_BUF_DEPTH));

endmodule

// File: verilog/route_arbiter.sv
/* YX route computation per head flit and one round-robin arbiter
   per output port */

`timescale 1ns/1ns
`include "noc_router_params.svh"

module route_arbiter (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  noc_router_pkg::router_addr_t router_addr_i,
  input  noc_router_pkg::flit_t        head_i [`ROUTER_PORTS],
  input  logic [`ROUTER_PORTS-1:0]     empty_i,
  input  logic [`ROUTER_PORTS-1:0]     avail_i,
  output logic [`ROUTER_PORTS-1:0]     pop_o,
  output noc_router_pkg::port_idx_t    sel_o [`ROUTER_PORTS],
  output logic [`ROUTER_PORTS-1:0]     send_o
);

  localparam noc_router_pkg::port_idx_t PORT_N = 2'd0;
  localparam noc_router_pkg::port_idx_t PORT_S = 2'd1;
  localparam noc_router_pkg::port_idx_t PORT_W = 2'd2;
  localparam noc_router_pkg::port_idx_t PORT_L = 2'd3;

  noc_router_pkg::port_idx_t route  [`ROUTER_PORTS];
  noc_router_pkg::port_idx_t last_q [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0]  req    [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0]  match  [`ROUTER_PORTS];

  // Y first, then X; eastbound heads fall through to L and are dropped there
  always_comb begin
    for (int i = 0; i < `ROUTER_PORTS; i++) begin
      if (head_i[i].dest.y < router_addr_i.y) begin
        route[i] = PORT_N;
      end else if (head_i[i].dest.y > router_addr_i.y) begin
        route[i] = PORT_S;
      end else if (head_i[i].dest.x < router_addr_i.x) begin
        route[i] = PORT_W;
      end else begin
        route[i] = PORT_L;
      end
    end
  end

  // req[o][i] set when input i has a head bound for output o
  always_comb begin
    for (int o = 0; o < `ROUTER_PORTS; o++) begin
      for (int i = 0; i < `ROUTER_PORTS; i++) begin
        req[o][i] = !empty_i[i] && (route[i] == noc_router_pkg::port_idx_t'(o));
      end
    end
  end

  always_comb begin
    noc_router_pkg::port_idx_t cand;
    logic                      found;
    send_o = '0;
    pop_o  = '0;
    for (int o = 0; o < `ROUTER_PORTS; o++) begin
      sel_o[o] = last_q[o];
      found    = 1'b0;
      // Search starts just after the last winner
      for (int k = 1; k <= `ROUTER_PORTS; k++) begin
        cand = noc_router_pkg::port_idx_t'((int'(last_q[o]) + k) % `ROUTER_PORTS);
        if (avail_i[o] && !found && req[o][cand]) begin
          found     = 1'b1;
          sel_o[o]  = cand;
          send_o[o] = 1'b1;
          pop_o[cand] = 1'b1;
        end
      end
    end
  end

  // Pointers start at L so that N is first in line
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int o = 0; o < `ROUTER_PORTS; o++) begin
        last_q[o] <= PORT_L;
      end
    end else begin
      for (int o = 0; o < `ROUTER_PORTS; o++) begin
        if (send_o[o]) begin
          last_q[o] <= sel_o[o];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `ROUTER_PORTS; i++) begin
      for (int o = 0; o < `ROUTER_PORTS; o++) begin
        match[i][o] = send_o[o] && (sel_o[o] == noc_router_pkg::port_idx_t'(i));
      end
    end
  end

  for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_chk
    // No east port on this edge of the mesh
    a_no_east: assert property (@(posedge clk) disable iff (!rst_n_i)
      !empty_i[i] |-> head_i[i].dest.x <= router_addr_i.x);

    // A popped flit goes to exactly one output, an unpopped one to none
    a_pop_send: assert property (@(posedge clk) disable iff (!rst_n_i)
      $countones(match[i]) == int'(pop_o[i]));
  end

endmodule

// File: verilog/crossbar_switch.sv
/* Registered 4x4 crossbar, one output register per port */

`timescale 1ns/1ns
`include "noc_router_params.svh"

module crossbar_switch (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  noc_router_pkg::flit_t     head_i [`ROUTER_PORTS],
  input  noc_router_pkg::port_idx_t sel_i  [`ROUTER_PORTS],
  input  logic [`ROUTER_PORTS-1:0]  send_i,
  output noc_router_pkg::link_t     link_o [`ROUTER_PORTS]
);

  logic [`ROUTER_PORTS-1:0] valid_q;
  noc_router_pkg::flit_t    flit_q [`ROUTER_PORTS];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= send_i;
    end
  end

  // Payload only loads on a grant
  always_ff @(posedge clk) begin
    for (int o = 0; o < `ROUTER_PORTS; o++) begin
      if (send_i[o]) begin
        flit_q[o] <= head_i[sel_i[o]];
      end
    end
  end

  always_comb begin
    for (int o = 0; o < `ROUTER_PORTS; o++) begin
      link_o[o].valid = valid_q[o];
      link_o[o].flit  = flit_q[o];
    end
  end

endmodule

// File: verilog/e_edge_router.sv
/* East-edge mesh router with N, S, W and L ports, YX routing,
   round-robin arbitration and credit flow control */

`timescale 1ns/1ns
`include "noc_router_params.svh"

module e_edge_router (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  noc_router_pkg::router_addr_t router_addr_i,
  input  noc_router_pkg::link_t        n_link_i,
  input  noc_router_pkg::link_t        s_link_i,
  input  noc_router_pkg::link_t        w_link_i,
  input  noc_router_pkg::link_t        l_link_i,
  input  logic                         n_credit_i,
  input  logic                         s_credit_i,
  input  logic                         w_credit_i,
  input  logic                         l_credit_i,
  output noc_router_pkg::link_t        n_link_o,
  output noc_router_pkg::link_t        s_link_o,
  output noc_router_pkg::link_t        w_link_o,
  output noc_router_pkg::link_t        l_link_o,
  output logic                         n_credit_o,
  output logic                         s_credit_o,
  output logic                         w_credit_o,
  output logic                         l_credit_o
);

  noc_router_pkg::link_t     link_in  [`ROUTER_PORTS];
  noc_router_pkg::link_t     link_out [`ROUTER_PORTS];
  noc_router_pkg::flit_t     head     [`ROUTER_PORTS];
  noc_router_pkg::port_idx_t sel      [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0]  credit_in;
  logic [`ROUTER_PORTS-1:0]  credit_out;
  logic [`ROUTER_PORTS-1:0]  empty;
  logic [`ROUTER_PORTS-1:0]  avail;
  logic [`ROUTER_PORTS-1:0]  pop;
  logic [`ROUTER_PORTS-1:0]  send;

  // Index order N S W L
  assign link_in[0] = n_link_i;
  assign link_in[1] = s_link_i;
  assign link_in[2] = w_link_i;
  assign link_in[3] = l_link_i;

  assign credit_in = {l_credit_i, w_credit_i, s_credit_i, n_credit_i};

  assign n_link_o = link_out[0];
  assign s_link_o = link_out[1];
  assign w_link_o = link_out[2];
  assign l_link_o = link_out[3];

  assign {l_credit_o, w_credit_o, s_credit_o, n_credit_o} = credit_out;

  for (genvar p = 0; p < `ROUTER_PORTS; p++) begin : g_port
    input_buffer u_ib (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .link_i   (link_in[p]),
      .pop_i    (pop[p]),
      .head_o   (head[p]),
      .empty_o  (empty[p]),
      .credit_o (credit_out[p])
    );

    credit_counter u_cc (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .send_i   (send[p]),
      .credit_i (credit_in[p]),
      .avail_o  (avail[p])
    );
  end

  route_arbiter u_arb (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .router_addr_i (router_addr_i),
    .head_i        (head),
    .empty_i       (empty),
    .avail_i       (avail),
    .pop_o         (pop),
    .sel_o         (sel),
    .send_o        (send)
  );

  crossbar_switch u_xbar (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .head_i  (head),
    .sel_i   (sel),
    .send_i  (send),
    .link_o  (link_out)
  );

endmodule

// File: tests/e_edge_router_tb.sv
/* Testbench for the east-edge router: random YX traffic against a scoreboard,
   credit back-pressure, round-robin and latency checks */

`timescale 1ns/1ns
`include "noc_router_params.svh"

module e_edge_router_tb;

  localparam int N_RAND      = 24;
  localparam int N_HOLD      = 8;
  localparam int N_ALT       = 12;
  localparam int TOTAL_FLITS = 4 * N_RAND + 4 * N_HOLD + 2 * N_ALT + 4;

  logic                         clk;
  logic                         rst_n;
  noc_router_pkg::router_addr_t own;
  noc_router_pkg::link_t        link_in [`ROUTER_PORTS] = '{default: '0};
  noc_router_pkg::link_t        link_out [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0]     cred_in = '0;
  logic [`ROUTER_PORTS-1:0]     cred_out;

  integer seed = 12;
  int     cyc;
  int     mism;
  int     fails;
  int     sent_total;
  int     recv_total;
  int     last_src = -1;
  int     lat_edge;
  int     up_cred [`ROUTER_PORTS] = '{default: `ROUTER_BUF_DEPTH};
  int     dn_cnt [`ROUTER_PORTS] = '{default: `ROUTER_BUF_DEPTH};
  int     sent [`ROUTER_PORTS] = '{default: 0};
  int     target [`ROUTER_PORTS] = '{default: 0};
  int     pulses [`ROUTER_PORTS] = '{default: 0};
  int     owed [`ROUTER_PORTS] = '{default: 0};
  bit     fixed [`ROUTER_PORTS] = '{default: 1'b0};
  bit     hold;
  bit     alt_on;
  bit     lat_on;
  noc_router_pkg::flit_t exp_q [16][$];

  e_edge_router dut0 (
    .clk (clk), .rst_n_i (rst_n), .router_addr_i (own),
    .n_link_i (link_in[0]), .s_link_i (link_in[1]),
    .w_link_i (link_in[2]), .l_link_i (link_in[3]),
    .n_credit_i (cred_in[0]), .s_credit_i (cred_in[1]),
    .w_credit_i (cred_in[2]), .l_credit_i (cred_in[3]),
    .n_link_o (link_out[0]), .s_link_o (link_out[1]),
    .w_link_o (link_out[2]), .l_link_o (link_out[3]),
    .n_credit_o (cred_out[0]), .s_credit_o (cred_out[1]),
    .w_credit_o (cred_out[2]), .l_credit_o (cred_out[3])
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Expected output port, Y before X
  function automatic int yx_port(noc_router_pkg::router_addr_t d);
    if (d.y < own.y) return 0;
    if (d.y > own.y) return 1;
    if (d.x < own.x) return 2;
    return 3;
  endfunction

  // Upstream drivers, downstream sinks and output monitors
  always @(posedge clk) begin
    noc_router_pkg::flit_t f;
    noc_router_pkg::flit_t e;
    int                    src;
    #1;
    cyc++;
    for (int p = 0; p < `ROUTER_PORTS; p++) begin
      if (sent_total == 0) begin
        assert (!link_out[p].valid && !cred_out[p]) else begin
          $display("Output %0d or credit %0d active before any flit was sent", p, p);
          fails++;
        end
      end
      if (cred_out[p]) begin
        up_cred[p]++;
        pulses[p]++;
        assert (up_cred[p] <= `ROUTER_BUF_DEPTH) else begin
          $display("Input %0d returned more credits than flits it received", p);
          fails++;
        end
      end
      if (link_out[p].valid) begin
        f = link_out[p].flit;
        src = int'(f.payload[7:6]);
        recv_total++;
        owed[p]++;
        dn_cnt[p]--;
        assert (dn_cnt[p] >= 0) else begin
          $display("Output %0d sent a flit with no downstream credit left", p);
          fails++;
        end
        assert (exp_q[src * 4 + p].size() > 0) else begin
          $display("Output %0d delivered a flit that input %0d never sent there", p, src);
          fails++;
        end
        if (exp_q[src * 4 + p].size() > 0) begin
          e = exp_q[src * 4 + p].pop_front();
          assert (f == e) else begin
            $display("Mismatch link_o[%0d].flit exp=%h got=%h", p, e, f);
            mism++;
          end
        end
        if (alt_on && p == 3) begin
          assert (src != last_src) else begin
            $display("Output L granted input %0d twice in a row", src);
            fails++;
          end
          last_src = src;
        end
        // Launch edge plus two
        if (lat_on) begin
          assert (cyc == lat_edge + 2) else begin
            $display("Mismatch latency_edge exp=%h got=%h", lat_edge + 2, cyc);
            mism++;
          end
        end
      end
      if (!alt_on) last_src = -1;
      cred_in[p] = 1'b0;
      if (owed[p] > 0 && !hold && ($random(seed) & 1) == 1) begin
        cred_in[p] = 1'b1;
        owed[p]--;
        dn_cnt[p]++;
      end
      link_in[p].valid = 1'b0;
      if (rst_n && sent[p] < target[p] && up_cred[p] > 0) begin
        if (fixed[p]) begin
          f.dest = own;
        end else begin
          f.dest.y = 4'($random(seed));
          f.dest.x = {2'b00, 2'($random(seed))};
        end
        f.payload = {2'(p), 6'(sent[p])};
        link_in[p].valid = 1'b1;
        link_in[p].flit  = f;
        exp_q[p * 4 + yx_port(f.dest)].push_back(f);
        up_cred[p]--;
        sent[p]++;
        sent_total++;
        lat_edge = cyc;
      end
    end
  end

  task automatic wait_drain();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      #3;
      busy = (recv_total < sent_total);
      for (int p = 0; p < `ROUTER_PORTS; p++) begin
        if (sent[p] < target[p] || owed[p] > 0) busy = 1'b1;
      end
    end
    repeat (3) @(posedge clk);
    #3;
  endtask

  initial begin
    int end_errs;
    end_errs = 0;
    rst_n = 1'b0;
    own.y = 4'd2;
    own.x = 4'd3;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    #2;
    for (int p = 0; p < `ROUTER_PORTS; p++) target[p] += N_RAND;
    wait_drain();
    // Downstream stalls, router may emit only its four credits per output
    hold = 1'b1;
    for (int p = 0; p < `ROUTER_PORTS; p++) target[p] += N_HOLD;
    repeat (30) @(posedge clk);
    #3 hold = 1'b0;
    wait_drain();
    // N and S both stream into L
    alt_on = 1'b1;
    fixed[0] = 1'b1;
    fixed[1] = 1'b1;
    target[0] += N_ALT;
    target[1] += N_ALT;
    wait_drain();
    alt_on = 1'b0;
    fixed[0] = 1'b0;
    fixed[1] = 1'b0;
    lat_on = 1'b1;
    for (int p = 0; p < `ROUTER_PORTS; p++) begin
      target[p]++;
      wait_drain();
    end
    lat_on = 1'b0;
    for (int p = 0; p < `ROUTER_PORTS; p++) begin
      assert (pulses[p] == sent[p]) else begin
        $display("Mismatch credit_o[%0d]_pulses exp=%h got=%h", p, sent[p], pulses[p]);
        end_errs++;
      end
    end
    $display("Mismatches: %0d, other errors: %0d", mism + end_errs, fails);
    if (mism + end_errs + fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (TOTAL_FLITS * 20 + 200) @(posedge clk);
    $display("Timeout: traffic did not drain in time");
    $display("Errors found");
    $finish;
  end

endmodule

// File: e_edge_router.f
+incdir+verilog
verilog/noc_router_pkg.sv
verilog/input_buffer.sv
verilog/credit_counter.sv
verilog/route_arbiter.sv
verilog/crossbar_switch.sv
verilog/e_edge_router.sv
tests/e_edge_router_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the router testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module e_edge_router_tb -Mdir obj_dir -f e_edge_router.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Ve_edge_router_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
